// ==== sources.f ====
+incdir+verilog
verilog/lbcPkg.sv
verilog/lbcReqDecode.sv
verilog/lbcBusSequencer.sv
verilog/lbcReadReturn.sv
verilog/lbcTop.sv
verification/lbcTop_checker.sv
verification/lbcTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
  --top-module lbcTb -f sources.f
out=$(./obj_dir/VlbcTb 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'sim passed'
then
  exit 0
fi
exit 1

// ==== verification/lbcTb.sv ====
`timescale 1ns/10ps
`include "lbc_config.svh"

module lbcTb;

  import lbcPkg::*;

  localparam real ClkPeriod     = 20.0;
  localparam int  TestCount     = 6;
  localparam int  CyclesPerTest = 40;

  logic       BUSCLK;
  logic       arstN;
  logic       go;
  logic       write;
  logic       line;
  logic       debugDest;
  logic       syncMode;
  logic       dataAck;
  logic       gnt;
  logic       frameIn;
  logic       irdyIn;
  logic       trdy;
  lbcDrive    drive;
  lbcReturn   ret;
  logic       cack;
  logic       busReq;
  logic       idle;
  integer     seed;
  logic [1:0] waitCnt;
  bit         ackOn;
  int         beats;
  int         loads;
  int         cacks;
  int         frames;
  int         busyCycles;
  bit         lastFrame;

  lbcTop dut0 (.*);

  initial
  begin
    BUSCLK = 1'b0;
    forever #(ClkPeriod / 2) BUSCLK = ~BUSCLK;
  end

  initial
  begin
    #(TestCount * CyclesPerTest * ClkPeriod);
    $display("sim failed");
    $fatal(1, "Watchdog expired before the tests finished");
  end

  //////////////////////////////
  // Bus target, core and monitor
  //////////////////////////////

  always @(posedge BUSCLK)
  begin
    if (trdy && drive.irdy)
    begin
      trdy    <= 1'b0;
      waitCnt <= 2'($random(seed));  // Next beat waits 0 to 3 cycles.
    end
    else if (!trdy && drive.irdy)
    begin
      if (waitCnt == 2'd0)
        trdy <= 1'b1;
      else
        waitCnt <= waitCnt - 2'd1;
    end
  end

  always @(posedge BUSCLK)
  begin
    dataAck <= ackOn && ret.dataEn && !dataAck;  // Core takes one entry every other cycle.
  end

  always @(posedge BUSCLK)
  begin
    if (drive.irdy && trdy && drive.oeData == '0)
    begin
      beats++;
      lastFrame = drive.frame;
    end
    loads      += (ret.loadMask != '0);
    cacks      += cack;
    frames     += drive.frame;
    busyCycles += !idle;
  end

  task automatic checkCount(input string name, input int expected, input int actual);
    assert (actual == expected)
    else
    begin
      $display("** Error: %s expected %0d actual %0d", name, expected, actual);
      $display("sim failed");
      $fatal(1, "%s count mismatch", name);
    end
  endtask

  task automatic checkTrue(input bit ok, input string what);
    assert (ok)
    else
    begin
      $display("sim failed");
      $fatal(1, "%s", what);
    end
  endtask

  function automatic bit outputsQuiet();
    return drive == '0 && !cack && !busReq && ret.loadMask == '0 && !ret.shift && !ret.dataEn;
  endfunction

  // One core request from go to the return of the sequencer to idle.
  task automatic runRequest(input string name, input bit wr, input bit ln, input bit dbg,
                            input int expBeats);
    beats      = 0;
    loads      = 0;
    cacks      = 0;
    frames     = 0;
    busyCycles = 0;
    go        <= 1'b1;
    write     <= wr;
    line      <= ln;
    debugDest <= dbg;
    @(posedge BUSCLK);
    while (!cack) @(posedge BUSCLK);
    go <= 1'b0;
    @(posedge BUSCLK);
    while (!idle) @(posedge BUSCLK);
    checkCount({name, " cack"}, 1, cacks);
    checkCount({name, " beats"}, expBeats, beats);
    if (beats > 0)
      checkTrue(!lastFrame, "frame was still high on the last read beat");
  endtask

  task automatic waitEmpty();
    while (ret.dataEn) @(posedge BUSCLK);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial
  begin
    seed      = 32'h1b94f8da;
    arstN     = 1'b0;
    go        = 1'b0;
    write     = 1'b0;
    line      = 1'b0;
    debugDest = 1'b0;
    syncMode  = 1'b1;
    dataAck   = 1'b0;
    gnt       = 1'b1;
    frameIn   = 1'b0;
    irdyIn    = 1'b0;
    trdy      = 1'b0;
    waitCnt   = 2'd0;
    ackOn     = 1'b1;
    repeat (3) @(posedge BUSCLK);
    checkTrue(outputsQuiet() && !idle, "a control output was not low during reset");
    arstN <= 1'b1;
    repeat (2)
    begin
      @(posedge BUSCLK);
      checkTrue(outputsQuiet(), "a control output was not low after reset");
    end

    runRequest("squash", 1'b0, 1'b0, 1'b1, 0);
    checkCount("squash frame cycles", 0, frames);
    checkCount("squash busy cycles", 0, busyCycles);

    gnt     <= 1'b0;  // Another master holds the bus for a while.
    frameIn <= 1'b1;
    fork
      runRequest("singleWrite", 1'b1, 1'b0, 1'b0, 0);
      begin
        // The bus turns quiet one condition at a time.
        repeat (2) @(posedge BUSCLK);
        frameIn <= 1'b0;
        irdyIn  <= 1'b1;
        repeat (2) @(posedge BUSCLK);
        irdyIn  <= 1'b0;
        repeat (2) @(posedge BUSCLK);
        gnt     <= 1'b1;
      end
    join
    checkCount("singleWrite frame cycles", 1, frames);

    runRequest("lineReadSync", 1'b0, 1'b1, 1'b0, `LBC_LINE_BEATS);
    waitEmpty();
    syncMode <= 1'b0;
    runRequest("lineReadAsync", 1'b0, 1'b1, 1'b0, `LBC_LINE_BEATS);
    runRequest("singleReadAsync", 1'b0, 1'b0, 1'b0, 1);

    // Back-pressure. The core stops taking data until the buffer has filled.
    waitEmpty();
    ackOn <= 1'b0;
    fork
      runRequest("backPressure", 1'b0, 1'b1, 1'b0, `LBC_LINE_BEATS);
      begin
        while (loads < `LBC_READ_DEPTH) @(posedge BUSCLK);
        repeat (6)
        begin
          @(posedge BUSCLK);
          checkTrue(loads <= `LBC_READ_DEPTH, "more loads than the read buffer holds");
        end
        checkCount("backPressure held beats", `LBC_READ_DEPTH, beats);
        ackOn <= 1'b1;
      end
    join

    // Debug write against a full buffer.
    waitEmpty();
    ackOn <= 1'b0;
    runRequest("fillRead0", 1'b0, 1'b0, 1'b0, 1);
    runRequest("fillRead1", 1'b0, 1'b0, 1'b0, 1);
    checkTrue(ret.full, "read buffer not full before the debug write");
    fork
      runRequest("debugWrite", 1'b1, 1'b0, 1'b1, 0);
      begin
        @(posedge BUSCLK);
        while (!(drive.irdy && trdy)) @(posedge BUSCLK);
        repeat (4)
        begin
          @(posedge BUSCLK);
          checkTrue(!idle, "debug write completed while the read buffer was full");
        end
        ackOn <= 1'b1;
      end
    join
    checkCount("debugWrite loads", 1, loads);
    waitEmpty();

    $display("sim passed");
    $finish;
  end

endmodule

// ==== verification/lbcTop_checker.sv ====
`timescale 1ns/10ps

module lbcTop_checker
(
  input logic             BUSCLK,
  input logic             arstN,
  input logic             gnt,
  input logic             frameIn,
  input logic             irdyIn,
  input logic             trdy,
  input logic             cack,
  input logic             idle,
  input logic             load,
  input lbcPkg::lbcDrive  drive,
  input lbcPkg::lbcReturn ret
);

  //////////////////////////////
  // Bus protocol
  //////////////////////////////

  // A new cycle may only start on a granted, quiet bus.
  frameNeedsGrant: assert property (@(posedge BUSCLK) disable iff (!arstN)
    $rose(drive.frame) |-> $past(gnt && !frameIn && !irdyIn))
    else $error("frame rose without a grant on a quiet bus");

  writeFrameOneCycle: assert property (@(posedge BUSCLK) disable iff (!arstN)
    $rose(drive.frame) && drive.oeData[0] |=> !drive.frame)
    else $error("write frame lasted more than one cycle");

  // Write data is driven from the address phase on.
  writeDataFromStart: assert property (@(posedge BUSCLK) disable iff (!arstN)
    $rose(drive.oeData[0]) |-> $rose(drive.frame))
    else $error("write data enable did not start with the address phase");

  writeDataHeld: assert property (@(posedge BUSCLK) disable iff (!arstN)
    drive.oeData[0] && drive.irdy && !trdy |=> drive.oeData[0])
    else $error("write data enable dropped before trdy");

  writeDataReleased: assert property (@(posedge BUSCLK) disable iff (!arstN)
    drive.oeData[0] && drive.irdy && trdy |=> !drive.oeData[0] && !drive.irdy)
    else $error("write data enable still high after trdy");

  //////////////////////////////
  // Read return
  //////////////////////////////

  noLoadWhenFull: assert property (@(posedge BUSCLK) disable iff (!arstN)
    ret.full |=> !load)
    else $error("load into a full read buffer");

  irdyOffWhenFull: assert property (@(posedge BUSCLK) disable iff (!arstN)
    ret.full && !drive.oeData[0] |=> !drive.irdy)
    else $error("irdy high on a read while the buffer was full");

  cackIsPulse: assert property (@(posedge BUSCLK) disable iff (!arstN)
    cack |=> !cack)
    else $error("cack lasted more than one cycle");

  quietInReset: assert property (@(posedge BUSCLK)
    !arstN |-> drive == '0 && !cack && !idle && !load && !ret.shift && !ret.dataEn)
    else $error("control output active during reset");

endmodule

bind lbcTop lbcTop_checker chk0
(
  .BUSCLK  (BUSCLK),
  .arstN   (arstN),
  .gnt     (gnt),
  .frameIn (frameIn),
  .irdyIn  (irdyIn),
  .trdy    (trdy),
  .cack    (cack),
  .idle    (idle),
  .load    (load),
  .drive   (drive),
  .ret     (ret)
);

// ==== verilog/lbcTop.sv ====
`timescale 1ns/10ps

module lbcTop
(
  input  logic             BUSCLK,
  input  logic             arstN,
  input  logic             go,
  input  logic             write,
  input  logic             line,
  input  logic             debugDest,
  input  logic             syncMode,
  input  logic             dataAck,
  input  logic             gnt,
  input  logic             frameIn,
  input  logic             irdyIn,
  input  logic             trdy,
  output lbcPkg::lbcDrive  drive,
  output lbcPkg::lbcReturn ret,
  output logic             cack,
  output logic             busReq,
  output logic             idle
);

  import lbcPkg::*;

  lbcReq req;
  logic  load;

  lbcReqDecode decode0
  (
    .BUSCLK    (BUSCLK),
    .arstN     (arstN),
    .go        (go),
    .write     (write),
    .line      (line),
    .debugDest (debugDest),
    .req       (req)
  );

  lbcBusSequencer seq0
  (
    .BUSCLK   (BUSCLK),
    .arstN    (arstN),
    .req      (req),
    .syncMode (syncMode),
    .gnt      (gnt),
    .frameIn  (frameIn),
    .irdyIn   (irdyIn),
    .trdy     (trdy),
    .full     (ret.full),
    .drive    (drive),
    .cack     (cack),
    .busReq   (busReq),
    .load     (load),
    .idle     (idle)
  );

  lbcReadReturn ret0
  (
    .BUSCLK   (BUSCLK),
    .arstN    (arstN),
    .load     (load),
    .syncMode (syncMode),
    .dataAck  (dataAck),
    .ret      (ret)
  );

endmodule

// ==== verilog/lbcReadReturn.sv ====
`timescale 1ns/10ps
`include "lbc_config.svh"

module lbcReadReturn
(
  input  logic             BUSCLK,
  input  logic             arstN,
  input  logic             load,
  input  logic             syncMode,
  input  logic             dataAck,
  output lbcPkg::lbcReturn ret
);

  // Room for depth plus one so the look-ahead sum cannot wrap.
  localparam int OccW = $clog2(`LBC_READ_DEPTH + 2);

  logic [OccW-1:0]            occ;
  logic [OccW-1:0]            occNext;
  logic [`LBC_READ_DEPTH-1:0] wrSlot;
  logic                       loadReg;
  logic                       shiftNow;
  logic                       pop;

  //////////////////////////////
  // Occupancy
  //////////////////////////////

  assign shiftNow = syncMode ? loadReg : dataAck;
  assign pop      = shiftNow && (occ != '0);  // Ignore a shift of an empty buffer.
  assign occNext  = occ + OccW'(load) - OccW'(pop);

  always_comb
  begin
    ret.loadMask = load ? wrSlot : '0;
    ret.shift    = shiftNow;
    ret.dataEn   = (occ != '0);
    // Full looks one load ahead, so the sequencer can drop irdy in time.
    ret.full     = (occNext >= OccW'(`LBC_READ_DEPTH));
  end

  always_ff @(posedge BUSCLK or negedge arstN)
  begin
    if (!arstN)
    begin
      occ     <= '0;
      wrSlot  <= `LBC_READ_DEPTH'(1);
      loadReg <= 1'b0;
    end
    else
    begin
      occ     <= occNext;
      loadReg <= load;
      if (load)
      begin
        wrSlot <= {wrSlot[`LBC_READ_DEPTH-2:0], wrSlot[`LBC_READ_DEPTH-1]};
      end
    end
  end

endmodule

// ==== verilog/lbcBusSequencer.sv ====
`timescale 1ns/10ps
`include "lbc_config.svh"

module lbcBusSequencer
(
  input  logic            BUSCLK,
  input  logic            arstN,
  input  lbcPkg::lbcReq   req,
  input  logic            syncMode,
  input  logic            gnt,
  input  logic            frameIn,
  input  logic            irdyIn,
  input  logic            trdy,
  input  logic            full,
  output lbcPkg::lbcDrive drive,
  output logic            cack,
  output logic            busReq,
  output logic            load,
  output logic            idle
);

  import lbcPkg::*;

  localparam int BeatW = $clog2(`LBC_LINE_BEATS);
  localparam logic [BeatW-1:0] BeatsLoad = BeatW'(`LBC_LINE_BEATS - 2);

  lbcState          state;
  lbcState          stateNext;
  logic [BeatW-1:0] beatCnt;
  logic [BeatW-1:0] beatCntNext;
  lbcDrive          driveNext;
  logic             addrNext;
  logic             addrHold;
  logic             fullReg;
  logic             debugWr;
  logic             beatOk;
  logic             busReqNow;
  logic             busReqReg;

  assign beatOk = drive.irdy & trdy;  // Beat accepted this cycle.

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb
  begin
    stateNext   = state;
    beatCntNext = beatCnt;
    cack        = 1'b0;
    load        = 1'b0;
    unique case (state)
      lbcPkg::idle:
      begin
        if (req.valid && req.squash)
        begin
          cack = 1'b1;
        end
        else if (req.valid && gnt && !frameIn && !irdyIn)
        begin
          cack      = syncMode;
          stateNext = req.write ? startWrite : startRead;
        end
      end
      startRead:
      begin
        cack        = ~syncMode;
        beatCntNext = BeatsLoad;
        stateNext   = req.line ? readMulti : readLast;
      end
      startWrite:
      begin
        cack      = ~syncMode;
        stateNext = writeAck;
      end
      readMulti:
      begin
        if (beatOk)
        begin
          load        = 1'b1;
          beatCntNext = beatCnt - BeatW'(1);
          if (beatCnt == '0)
          begin
            stateNext = readLast;  // Next beat is the last one.
          end
        end
      end
      readLast:
      begin
        if (beatOk)
        begin
          load      = 1'b1;
          stateNext = lbcPkg::idle;
        end
      end
      writeAck:
      begin
        if (trdy)
        begin
          // A debug write posts a completion entry into the read buffer.
          if (!debugWr)
          begin
            stateNext = lbcPkg::idle;
          end
          else if (fullReg)
          begin
            stateNext = debugAck;
          end
          else
          begin
            load      = 1'b1;
            stateNext = lbcPkg::idle;
          end
        end
      end
      debugAck:
      begin
        if (!fullReg)
        begin
          load      = 1'b1;
          stateNext = lbcPkg::idle;
        end
      end
      default:
      begin
        stateNext = lbcPkg::idle;
      end
    endcase
  end

  //////////////////////////////
  // Bus drives
  //////////////////////////////

  always_comb
  begin
    // Frame stays up in readLast while the buffer holds off the final beat.
    driveNext.frame = (stateNext inside {startRead, startWrite, readMulti}) ||
                      (stateNext == readLast && full);
    driveNext.irdy  = ((stateNext inside {readMulti, readLast}) && !full) ||
                      stateNext == writeAck;
    addrNext         = !(stateNext inside {lbcPkg::idle, debugAck});
    driveNext.oeCtl  = {`LBC_OE_WIDTH{stateNext inside {startRead, startWrite}}};
    driveNext.oeAddr = {`LBC_OE_WIDTH{addrNext | addrHold}};
    driveNext.oeData = {`LBC_OE_WIDTH{stateNext inside {startWrite, writeAck}}};
  end

  assign busReqNow = req.valid & ~req.squash & ~(state inside {startRead, startWrite});
  assign busReq    = syncMode ? busReqReg : busReqNow;

  always_ff @(posedge BUSCLK or negedge arstN)
  begin
    if (!arstN)
    begin
      state     <= lbcPkg::idle;
      beatCnt   <= '0;
      drive     <= '0;
      addrHold  <= 1'b0;
      fullReg   <= 1'b0;
      debugWr   <= 1'b0;
      busReqReg <= 1'b0;
      idle      <= 1'b0;
    end
    else
    begin
      state     <= stateNext;
      beatCnt   <= beatCntNext;
      drive     <= driveNext;
      addrHold  <= addrNext;    // Address enables trail the bus cycle by one clock.
      fullReg   <= full;
      busReqReg <= busReqNow;
      idle      <= (stateNext == lbcPkg::idle);
      if (state == lbcPkg::idle)
      begin
        debugWr <= req.debugDest;
      end
    end
  end

endmodule

// ==== verilog/lbcReqDecode.sv ====
`timescale 1ns/10ps

module lbcReqDecode
(
  input  logic          BUSCLK,
  input  logic          arstN,
  input  logic          go,
  input  logic          write,
  input  logic          line,
  input  logic          debugDest,
  output lbcPkg::lbcReq req
);

  import lbcPkg::*;

  logic  qualWrite;
  logic  qualSquash;
  lbcReq reqNext;

  assign qualWrite  = go & write;
  assign qualSquash = go & debugDest & ~write;  // Reads from the debug port go nowhere.

  always_comb
  begin
    reqNext = req;
    // A squash is answered in one cycle, so its valid is only offered once.
    reqNext.valid = go & ~(req.valid & req.squash);
    if (go)
    begin
      reqNext.write     = qualWrite;
      reqNext.line      = line & ~write;
      reqNext.debugDest = debugDest;
      reqNext.squash    = qualSquash;
    end
  end

  // The request fields hold their value after go falls.
  always_ff @(posedge BUSCLK or negedge arstN)
  begin
    if (!arstN)
    begin
      req <= '0;
    end
    else
    begin
      req <= reqNext;
    end
  end

endmodule

// ==== verilog/lbcPkg.sv ====
`include "lbc_config.svh"

package lbcPkg;

  // Registered core request as seen by the bus sequencer.
  typedef struct packed {
    logic valid;
    logic write;
    logic line;
    logic debugDest;
    logic squash;    // Debug-destination read, completed without a bus cycle.
  } lbcReq;

  // Registered local-bus drives.
  typedef struct packed {
    logic                     frame;
    logic                     irdy;
    logic [`LBC_OE_WIDTH-1:0] oeCtl;
    logic [`LBC_OE_WIDTH-1:0] oeAddr;
    logic [`LBC_OE_WIDTH-1:0] oeData;
  } lbcDrive;

  typedef struct packed {
    logic [`LBC_READ_DEPTH-1:0] loadMask;  // One-hot slot written by this load.
    logic                       shift;
    logic                       dataEn;
    logic                       full;
  } lbcReturn;

  // One state bit per state.
  typedef enum logic [6:0] {
    idle       = 7'b0000001,
    startRead  = 7'b0000010,
    startWrite = 7'b0000100,
    readMulti  = 7'b0001000,
    readLast   = 7'b0010000,
    writeAck   = 7'b0100000,
    debugAck   = 7'b1000000
  } lbcState;

endpackage

// ==== verilog/lbc_config.svh ====
`ifndef LBC_CONFIG_SVH
`define LBC_CONFIG_SVH

//////////////////////////////
// Local-bus master sizing
//////////////////////////////

// Data beats in one line read. Must be two or more.
`define LBC_LINE_BEATS 4

// Entries in the read-return buffer.
`define LBC_READ_DEPTH 2

// Width of each output-enable group (control, address, data).
`define LBC_OE_WIDTH 4

`endif
